/* design/flow_arb_rr.sv */
// Round-robin arbiter with ready-valid grant and a pointer that advances on each completed pop
`include "flow_mux_defines.svh"

module flow_arb_rr (
  input  logic                   clk,
  input  logic                   rst_n,
  input  flow_mux_pkg::req_vec_t req_valid,
  output flow_mux_pkg::req_vec_t req_ready,
  input  logic                   pop_ready,
  output logic                   pop_valid
);

  import flow_mux_pkg::*;

  // ----------------------------------------------------------------------
  // Priority pointer and grant
  // ----------------------------------------------------------------------

  // Requester with the highest priority this cycle
  src_id_t ptr;

  // One-hot or zero grant, before pop_ready gating
  req_vec_t grant;

  // Index of the granted requester
  src_id_t grant_idx;

  // Index after the granted one, wrapping at the last requester
  src_id_t next_ptr;

  logic pop_fire;

  // Scan upward from the pointer, wrapping, first valid wins
  always_comb begin
    int idx;
    logic hit;
    grant     = '0;
    grant_idx = '0;
    hit       = 1'b0;
    for (int k = 0; k < `FM_NUM_REQ; k++) begin
      idx = (int'(ptr) + k) % `FM_NUM_REQ;
      if (!hit && req_valid[idx]) begin
        hit        = 1'b1;
        grant[idx] = 1'b1;
        grant_idx  = src_id_t'(idx);
      end
    end
  end

  // ----------------------------------------------------------------------
  // Handshake
  // ----------------------------------------------------------------------

  // Output valid whenever any source has a word
  assign pop_valid = |req_valid;

  // Only the winner sees ready, and only when downstream accepts
  assign req_ready = grant & {`FM_NUM_REQ{pop_ready}};

  assign pop_fire = pop_valid && pop_ready;

  assign next_ptr = (int'(grant_idx) == `FM_NUM_REQ - 1) ? '0 : grant_idx + 1'b1;

  // ----------------------------------------------------------------------
  // Pointer update
  // ----------------------------------------------------------------------

  // Moves past the winner on the edge that completes the pop
  // Held under back-pressure, so the grant stays put
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ptr <= '0;
    end else if (pop_fire) begin
      ptr <= next_ptr;
    end
  end

endmodule : flow_arb_rr

/* design/flow_ingress_fifo.sv */
// Ingress FIFO with ready-valid push and pop, full and empty tracking by wrap-bit pointers
`include "flow_mux_defines.svh"

module flow_ingress_fifo (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                push_valid,
  output logic                push_ready,
  input  flow_mux_pkg::data_t push_data,
  output logic                pop_valid,
  input  logic                pop_ready,
  output flow_mux_pkg::data_t pop_data
);

  import flow_mux_pkg::*;

  // Address bits of the storage array
  localparam int ADDR_W = $clog2(`FM_FIFO_DEPTH);

  // ----------------------------------------------------------------------
  // Storage and pointers
  // ----------------------------------------------------------------------

  // Payload storage
  data_t mem [`FM_FIFO_DEPTH];

  // Pointers carry one extra wrap bit to tell full from empty
  logic [ADDR_W:0] wr_ptr;
  logic [ADDR_W:0] rd_ptr;

  logic full;
  logic empty;
  logic push_fire;
  logic pop_fire;

  // ----------------------------------------------------------------------
  // Status
  // ----------------------------------------------------------------------

  // Same address on the same lap
  assign empty = (wr_ptr == rd_ptr);

  // Same address with the writer one lap ahead
  assign full = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

  // Push refused only when full
  // A pop in the same cycle does not open a slot for the push
  assign push_ready = !full;
  assign pop_valid  = !empty;

  assign push_fire = push_valid && push_ready;
  assign pop_fire  = pop_valid && pop_ready;

  // ----------------------------------------------------------------------
  // Write side
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (push_fire) begin
      mem[wr_ptr[ADDR_W-1:0]] <= push_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (push_fire) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // Read side
  // ----------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
    end else if (pop_fire) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // Head word straight from the array
  // Valid the cycle after it was written
  assign pop_data = mem[rd_ptr[ADDR_W-1:0]];

endmodule : flow_ingress_fifo

/* design/flow_mux_pkg.sv */
// Shared types of the flow multiplexer: word, source index, request vector, output beat
`include "flow_mux_defines.svh"

package flow_mux_pkg;

  // ----------------------------------------------------------------------
  // Vector types
  // ----------------------------------------------------------------------

  // One payload word
  typedef logic [`FM_DATA_W-1:0] data_t;

  // Index of a requester, 2 bits for four sources
  typedef logic [$clog2(`FM_NUM_REQ)-1:0] src_id_t;

  // One bit per requester, used for valid, ready and grant vectors
  typedef logic [`FM_NUM_REQ-1:0] req_vec_t;

  // ----------------------------------------------------------------------
  // Output beat
  // ----------------------------------------------------------------------

  // Source index in the upper bits, payload below
  typedef struct packed {
    src_id_t src;
    data_t   data;
  } flow_beat_t;

endpackage : flow_mux_pkg

/* design/flow_mux_rr.sv */
// Flow-controlled round-robin multiplexer: arbiter plus selection of granted word and source
`include "flow_mux_defines.svh"

module flow_mux_rr (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  flow_mux_pkg::req_vec_t                      push_valid,
  output flow_mux_pkg::req_vec_t                      push_ready,
  input  flow_mux_pkg::data_t [`FM_NUM_REQ-1:0]       push_data,
  input  logic                                        pop_ready,
  output logic                                        pop_valid,
  output flow_mux_pkg::flow_beat_t                    pop_beat
);

  import flow_mux_pkg::*;

  // ----------------------------------------------------------------------
  // Arbitration
  // ----------------------------------------------------------------------

  flow_arb_rr u_arb (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (push_valid),
    .req_ready (push_ready),
    .pop_ready (pop_ready),
    .pop_valid (pop_valid)
  );

  // ----------------------------------------------------------------------
  // Data selection
  // ----------------------------------------------------------------------

  // Source whose ready and valid are both high, 0 when none
  src_id_t grant_idx;

  // The arbiter grant is one-hot, so at most one match
  always_comb begin
    grant_idx = '0;
    for (int i = 0; i < `FM_NUM_REQ; i++) begin
      if (push_ready[i] && push_valid[i]) begin
        grant_idx = src_id_t'(i);
      end
    end
  end

  // Zero-latency path from FIFO head to output beat
  assign pop_beat.src  = grant_idx;
  assign pop_beat.data = push_data[grant_idx];

endmodule : flow_mux_rr

/* design/flow_mux_top.sv */
// Top level of the four-way merge: one ingress FIFO per requester feeding the RR multiplexer
`include "flow_mux_defines.svh"

module flow_mux_top (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  flow_mux_pkg::req_vec_t                push_valid,
  output flow_mux_pkg::req_vec_t                push_ready,
  input  flow_mux_pkg::data_t [`FM_NUM_REQ-1:0] push_data,
  input  logic                                  pop_ready,
  output logic                                  pop_valid,
  output flow_mux_pkg::flow_beat_t              pop_beat
);

  import flow_mux_pkg::*;

  // ----------------------------------------------------------------------
  // FIFO to multiplexer links
  // ----------------------------------------------------------------------

  // Not-empty flags of the FIFOs
  req_vec_t fifo_valid;

  // Grant back to the FIFOs, one-hot or zero
  req_vec_t fifo_ready;

  // Head word of each FIFO
  data_t [`FM_NUM_REQ-1:0] fifo_data;

  // ----------------------------------------------------------------------
  // Ingress FIFOs
  // ----------------------------------------------------------------------

  for (genvar i = 0; i < `FM_NUM_REQ; i++) begin : g_fifo
    flow_ingress_fifo u_fifo (
      .clk        (clk),
      .rst_n      (rst_n),
      .push_valid (push_valid[i]),
      .push_ready (push_ready[i]),
      .push_data  (push_data[i]),
      .pop_valid  (fifo_valid[i]),
      .pop_ready  (fifo_ready[i]),
      .pop_data   (fifo_data[i])
    );
  end

  // ----------------------------------------------------------------------
  // Round-robin merge
  // ----------------------------------------------------------------------

  // FIFO heads act as the requesters of the multiplexer
  flow_mux_rr u_mux (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (fifo_valid),
    .push_ready (fifo_ready),
    .push_data  (fifo_data),
    .pop_ready  (pop_ready),
    .pop_valid  (pop_valid),
    .pop_beat   (pop_beat)
  );

endmodule : flow_mux_top

/* include/flow_mux_defines.svh */
// Configuration macros for the round-robin flow multiplexer: requester count, data width, depth
`ifndef FLOW_MUX_DEFINES_SVH
`define FLOW_MUX_DEFINES_SVH

// ----------------------------------------------------------------------
// Fixed configuration of the four-way merge
// ----------------------------------------------------------------------

// Number of independent requesters feeding the multiplexer
`define FM_NUM_REQ 4

// Width of one payload word
`define FM_DATA_W 16

// Entries per ingress FIFO
// Must stay a power of two, the FIFO pointers wrap on it
`define FM_FIFO_DEPTH 4

`endif

/* list.f */
+incdir+include
design/flow_mux_pkg.sv
design/flow_ingress_fifo.sv
design/flow_arb_rr.sv
design/flow_mux_rr.sv
design/flow_mux_top.sv
verification/flow_mux_sva.sv
verification/flow_mux_tb.sv

/* verification/flow_mux_sva.sv */
// Assertions for the flow multiplexer top: reset values, valid OR, one-hot ready, hold rules
`include "flow_mux_defines.svh"

module flow_mux_sva (
  input logic                                  clk,
  input logic                                  rst_n,
  input flow_mux_pkg::req_vec_t                push_ready,
  input flow_mux_pkg::req_vec_t                fifo_valid,
  input flow_mux_pkg::req_vec_t                fifo_ready,
  input flow_mux_pkg::data_t [`FM_NUM_REQ-1:0] fifo_data,
  input logic                                  pop_ready,
  input logic                                  pop_valid,
  input flow_mux_pkg::flow_beat_t              pop_beat
);

  timeunit 1ns;
  timeprecision 100ps;

  import flow_mux_pkg::*;

  // Number of assertion failures
  int assert_fails = 0;

  // ----------------------------------------------------------------------
  // Reset and arbitration
  // ----------------------------------------------------------------------

  // Empty FIFOs and an idle output while reset is held
  a_reset_values: assert property (@(posedge clk)
    !rst_n |-> (push_ready == '1) && !pop_valid)
    else begin
      assert_fails++;
      $error("reset values wrong on push_ready or pop_valid");
    end

  a_valid_or: assert property (@(posedge clk) disable iff (!rst_n)
    pop_valid == |fifo_valid)
    else begin
      assert_fails++;
      $error("pop_valid differs from the OR of the FIFO valids");
    end

  // At most one FIFO popped per cycle
  a_ready_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(fifo_ready))
    else begin
      assert_fails++;
      $error("more than one FIFO ready in the same cycle");
    end

  // ----------------------------------------------------------------------
  // Back-pressure
  // ----------------------------------------------------------------------

  // Output valid never drops without a pop
  a_valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    pop_valid && !pop_ready |=> pop_valid)
    else begin
      assert_fails++;
      $error("pop_valid dropped while pop_ready was low");
    end

  // Offered beat holds across back-to-back stalled cycles
  a_beat_stable: assert property (@(posedge clk) disable iff (!rst_n)
    !pop_ready && $past(!pop_ready) && $past(pop_valid) |-> $stable(pop_beat))
    else begin
      assert_fails++;
      $error("pop_beat changed while pop_ready stayed low");
    end

  // A head that is not popped keeps its word
  for (genvar i = 0; i < `FM_NUM_REQ; i++) begin : g_head
    a_head_hold: assert property (@(posedge clk) disable iff (!rst_n)
      fifo_valid[i] && !fifo_ready[i] |=> fifo_valid[i] && $stable(fifo_data[i]))
      else begin
        assert_fails++;
        $error("FIFO head changed without a pop");
      end
  end

endmodule : flow_mux_sva

/* verification/flow_mux_tb.sv */
// Testbench for the flow multiplexer: clock, reset, stimulus table, queue model, checks, summary
`include "flow_mux_defines.svh"

module flow_mux_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import flow_mux_pkg::*;

  // pop_ready setting of a table row
  localparam logic [1:0] POP_LOW  = 2'd0;
  localparam logic [1:0] POP_HIGH = 2'd1;
  localparam logic [1:0] POP_RAND = 2'd2;

  localparam int NUM_ROWS      = 8;
  localparam int DRAIN_TIMEOUT = 200;

  // One table row with push mask, pop_ready setting and cycle count
  typedef struct packed {
    req_vec_t   mask;
    logic [1:0] pop_mode;
    logic [7:0] cycles;
  } stim_row_t;

  logic                    clk;
  logic                    rst_n;
  req_vec_t                push_valid;
  req_vec_t                push_ready;
  data_t [`FM_NUM_REQ-1:0] push_data;
  logic                    pop_ready;
  logic                    pop_valid;
  flow_beat_t              pop_beat;

  // Pushes seen at the falling edge
  // They complete on the next rising edge
  req_vec_t push_acc;

  // Words accepted and not yet popped with one queue per source
  data_t   ref_q [`FM_NUM_REQ][$];
  src_id_t ref_ptr;

  logic [31:0] lcg_state;
  int          error_count;
  int          check_count;
  int          push_count;
  int          pop_count;
  logic        drained;

  // ----------------------------------------------------------------------
  // Stimulus table
  // ----------------------------------------------------------------------

  stim_row_t stim_tbl [NUM_ROWS] = '{
    '{4'hF, POP_HIGH, 8'd40},  // All busy for strict 0 1 2 3 rotation
    '{4'h0, POP_HIGH, 8'd20},
    '{4'hA, POP_HIGH, 8'd30},  // Sources 1 and 3 only
    '{4'h0, POP_HIGH, 8'd10},
    '{4'hF, POP_LOW,  8'd12},  // Stalled output lets the FIFOs fill
    '{4'hF, POP_RAND, 8'd60},
    '{4'h5, POP_RAND, 8'd30},
    '{4'h0, POP_HIGH, 8'd20}
  };

  flow_mux_top dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .push_data  (push_data),
    .pop_ready  (pop_ready),
    .pop_valid  (pop_valid),
    .pop_beat   (pop_beat)
  );

  bind flow_mux_top flow_mux_sva u_sva (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_ready (push_ready),
    .fifo_valid (fifo_valid),
    .fifo_ready (fifo_ready),
    .fifo_data  (fifo_data),
    .pop_ready  (pop_ready),
    .pop_valid  (pop_valid),
    .pop_beat   (pop_beat)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic all_queues_empty();
    logic empty;
    empty = 1'b1;
    for (int i = 0; i < `FM_NUM_REQ; i++) begin
      if (ref_q[i].size() != 0) begin
        empty = 1'b0;
      end
    end
    return empty;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("ERROR at %0t ns: %s expected %0h actual %0h", $time, name, expected, actual);
    end
  endtask

  // One clock of stimulus applied 2 ns after the rising edge
  task automatic drive_cycle(input req_vec_t mask, input logic [1:0] mode);
    logic [31:0] rnd;
    @(posedge clk);
    #2;
    for (int i = 0; i < `FM_NUM_REQ; i++) begin
      // An offered word stays on the bus until it is taken
      if (!(push_valid[i] && !push_acc[i])) begin
        push_valid[i] = mask[i];
        if (mask[i]) begin
          rnd = lcg_next();
          push_data[i] = rnd[31:16];
        end
      end
    end
    case (mode)
      POP_LOW:  pop_ready = 1'b0;
      POP_HIGH: pop_ready = 1'b1;
      default: begin
        rnd = lcg_next();
        pop_ready = rnd[16];
      end
    endcase
  endtask

  // ----------------------------------------------------------------------
  // Reference model sampled at the falling edge
  // ----------------------------------------------------------------------

  always @(negedge clk) begin : ref_model
    int win;
    win = -1;
    if (rst_n) begin
      // First non-empty source at or after the pointer with wrap
      for (int k = 0; k < `FM_NUM_REQ; k++) begin
        if (win < 0 && ref_q[(int'(ref_ptr) + k) % `FM_NUM_REQ].size() != 0) begin
          win = (int'(ref_ptr) + k) % `FM_NUM_REQ;
        end
      end
      check_value("pop_valid", win >= 0, pop_valid);
      // Full after FM_FIFO_DEPTH outstanding words
      for (int i = 0; i < `FM_NUM_REQ; i++) begin
        check_value($sformatf("push_ready[%0d]", i),
                    ref_q[i].size() < `FM_FIFO_DEPTH, push_ready[i]);
      end
      // Every output handshake counts, expected or not
      if (pop_valid && pop_ready) begin
        pop_count++;
        if (win >= 0) begin
          check_value("pop_beat.src", win, pop_beat.src);
          check_value("pop_beat.data", ref_q[win][0], pop_beat.data);
          void'(ref_q[win].pop_front());
          ref_ptr = src_id_t'((win + 1) % `FM_NUM_REQ);
        end
      end
      for (int i = 0; i < `FM_NUM_REQ; i++) begin
        push_acc[i] = push_valid[i] && push_ready[i];
        if (push_acc[i]) begin
          ref_q[i].push_back(push_data[i]);
          push_count++;
        end
      end
    end else begin
      push_acc = '0;
    end
  end

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin : main
    int timeout;
    int fails;
    lcg_state   = 32'h56ba_b628;
    rst_n       = 1'b0;
    push_valid  = '0;
    push_data   = '0;
    pop_ready   = 1'b0;
    push_acc    = '0;
    ref_ptr     = '0;
    error_count = 0;
    check_count = 0;
    push_count  = 0;
    pop_count   = 0;
    drained     = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // Idle state right after reset
    @(negedge clk);
    check_value("push_ready", {`FM_NUM_REQ{1'b1}}, push_ready);
    check_value("pop_valid", 1'b0, pop_valid);

    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int c = 0; c < int'(stim_tbl[r].cycles); c++) begin
        drive_cycle(stim_tbl[r].mask, stim_tbl[r].pop_mode);
      end
    end

    // Drain with pushes off and the output always ready
    timeout = 0;
    while (!drained && timeout < DRAIN_TIMEOUT) begin
      drive_cycle('0, POP_HIGH);
      @(negedge clk);
      #1;
      drained = !pop_valid && all_queues_empty();
      timeout++;
    end
    if (!drained) begin
      $display("Output did not drain within %0d cycles, words are still outstanding",
               DRAIN_TIMEOUT);
    end
    check_value("words popped", push_count, pop_count);

    fails = dut.u_sva.assert_fails;
    $display("Summary: %0d checks, %0d errors, %0d assertion failures, %0d pushed, %0d popped",
             check_count, error_count, fails, push_count, pop_count);
    if (error_count == 0 && fails == 0 && drained) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule : flow_mux_tb
